// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= pipe_regs_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/exe_mem_reg.sv ====
`include "pipe_defs.svh"

module exe_mem_reg
    import rv32_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  logic     valid_i,
    input  word_t    pc_i,
    input  word_t    alu_i,
    input  word_t    rs2_i,
    input  logic     mem_read_i,
    input  logic     mem_write_i,
    input  funct3_t  funct3_i,
    input  mar_sel_e mar_sel_i,
    output logic     valid_o,
    output word_t    pc_o,
    output word_t    alu_o,
    output word_t    mem_addr_o,
    output word_t    mem_wdata_o,
    output byte_en_t mem_byte_en_o,
    output logic     mem_read_o,
    output logic     mem_write_o,
    output logic     mem_trap_o
);

    word_t    req_addr;
    byte_en_t req_byte_en;
    logic     req_trap;
    logic     mem_op_ld;
    logic     valid_q;
    logic     read_q;
    logic     write_q;
    logic     trap_q;

    // request is formed from the incoming packet, ready at the edge
    mem_req_gen u_req_gen (
        .pc_i        (pc_i),
        .alu_i       (alu_i),
        .mar_sel_i   (mar_sel_i),
        .mem_read_i  (mem_read_i),
        .mem_write_i (mem_write_i),
        .funct3_i    (funct3_i),
        .addr_o      (req_addr),
        .byte_en_o   (req_byte_en),
        .trap_o      (req_trap)
    );

    assign mem_op_ld = load_i & valid_i & (mem_read_i | mem_write_i);

    // control flags move with valid, read wins over write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            read_q  <= 1'b0;
            write_q <= 1'b0;
            trap_q  <= 1'b0;
        end else if (load_i) begin
            valid_q <= valid_i;
            read_q  <= mem_read_i;
            write_q <= mem_write_i & ~mem_read_i;
            trap_q  <= req_trap;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o  <= `RESET_PC;
            alu_o <= '0;
        end else if (load_i && valid_i) begin
            pc_o  <= pc_i;
            alu_o <= alu_i;
        end
    end

    // data cache request, held until the next memory op
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_addr_o    <= '0;
            mem_wdata_o   <= '0;
            mem_byte_en_o <= '0;
        end else if (mem_op_ld) begin
            mem_addr_o    <= req_addr;
            mem_wdata_o   <= rs2_i;
            mem_byte_en_o <= req_byte_en;
        end
    end

    assign valid_o     = valid_q;
    assign mem_read_o  = valid_q & read_q;
    assign mem_write_o = valid_q & write_q;
    assign mem_trap_o  = valid_q & trap_q;

endmodule

// ==== design/mem_req_gen.sv ====
`include "pipe_defs.svh"

module mem_req_gen
    import rv32_pipe_pkg::*;
(
    input  word_t    pc_i,
    input  word_t    alu_i,
    input  mar_sel_e mar_sel_i,
    input  logic     mem_read_i,
    input  logic     mem_write_i,
    input  funct3_t  funct3_i,
    output word_t    addr_o,
    output byte_en_t byte_en_o,
    output logic     trap_o
);

    word_t raw_addr;
    word_t word_addr;

    always_comb begin
        unique case (mar_sel_i)
            pc_sel:  raw_addr = pc_i;
            alu_sel: raw_addr = alu_i;
            default: raw_addr = alu_i;
        endcase
    end

    // sub-word accesses go out on the containing word
    assign word_addr = {raw_addr[`XLEN-1:2], 2'b00};

    // masks shift by the byte offset; offset 3 on a halfword keeps only 1000
    always_comb begin
        addr_o    = raw_addr;
        byte_en_o = '0;
        trap_o    = 1'b0;

        if (mem_read_i) begin
            case (load_funct3_e'(funct3_i))
                lw: begin
                    byte_en_o = 4'b1111;
                end
                lh, lhu: begin
                    byte_en_o = 4'b0011 << raw_addr[1:0];
                    addr_o    = word_addr;
                end
                lb, lbu: begin
                    byte_en_o = 4'b0001 << raw_addr[1:0];
                    addr_o    = word_addr;
                end
                default: trap_o = 1'b1;
            endcase
        end else if (mem_write_i) begin
            case (store_funct3_e'(funct3_i))
                sw: begin
                    byte_en_o = 4'b1111;
                end
                sh: begin
                    byte_en_o = 4'b0011 << raw_addr[1:0];
                    addr_o    = word_addr;
                end
                sb: begin
                    byte_en_o = 4'b0001 << raw_addr[1:0];
                    addr_o    = word_addr;
                end
                default: trap_o = 1'b1;
            endcase
        end
    end

endmodule

// ==== design/pipe_regs_top.sv ====
`include "pipe_defs.svh"

module pipe_regs_top
    import rv32_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  logic     in_valid_i,
    input  word_t    in_pc_i,
    input  word_t    in_alu_i,
    input  word_t    in_rs2_i,
    input  logic     in_mem_read_i,
    input  logic     in_mem_write_i,
    input  funct3_t  in_funct3_i,
    input  mar_sel_e in_mar_sel_i,
    input  word_t    mem_rdata_i,
    output word_t    mem_addr_o,
    output word_t    mem_wdata_o,
    output byte_en_t mem_byte_en_o,
    output logic     mem_read_o,
    output logic     mem_write_o,
    output logic     mem_trap_o,
    output logic     mem_valid_o,
    output logic     wb_valid_o,
    output word_t    wb_pc_o,
    output word_t    wb_alu_o,
    output word_t    wb_rdata_o
);

    // pc, alu, rs2, read, write, funct3, mar_sel
    localparam int DE_W = 3 * `XLEN + 6;
    // pc, alu, rdata
    localparam int WB_W = 3 * `XLEN;

    logic [DE_W-1:0] de_data;
    logic            de_valid;
    logic [WB_W-1:0] wb_data;
    word_t           em_pc;
    word_t           em_alu;

    pipe_stage_reg #(
        .WIDTH     (DE_W),
        .RESET_VAL ({`RESET_PC, {(DE_W - `XLEN){1'b0}}})
    ) u_dec_exe (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load_i),
        .valid_i (in_valid_i),
        .data_i  ({in_pc_i, in_alu_i, in_rs2_i, in_mem_read_i, in_mem_write_i,
                   in_funct3_i, in_mar_sel_i}),
        .valid_o (de_valid),
        .data_o  (de_data)
    );

    exe_mem_reg u_exe_mem (
        .clk           (clk),
        .rst           (rst),
        .load_i        (load_i),
        .valid_i       (de_valid),
        .pc_i          (de_data[DE_W-1 -: `XLEN]),
        .alu_i         (de_data[DE_W-1-`XLEN -: `XLEN]),
        .rs2_i         (de_data[DE_W-1-2*`XLEN -: `XLEN]),
        .mem_read_i    (de_data[5]),
        .mem_write_i   (de_data[4]),
        .funct3_i      (de_data[3:1]),
        .mar_sel_i     (mar_sel_e'(de_data[0])),
        .valid_o       (mem_valid_o),
        .pc_o          (em_pc),
        .alu_o         (em_alu),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_byte_en_o (mem_byte_en_o),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .mem_trap_o    (mem_trap_o)
    );

    // read data is sampled one edge after the request goes out
    pipe_stage_reg #(
        .WIDTH     (WB_W),
        .RESET_VAL ({`RESET_PC, {(WB_W - `XLEN){1'b0}}})
    ) u_mem_wb (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load_i),
        .valid_i (mem_valid_o),
        .data_i  ({em_pc, em_alu, mem_rdata_i}),
        .valid_o (wb_valid_o),
        .data_o  (wb_data)
    );

    assign wb_pc_o    = wb_data[WB_W-1 -: `XLEN];
    assign wb_alu_o   = wb_data[WB_W-1-`XLEN -: `XLEN];
    assign wb_rdata_o = wb_data[`XLEN-1:0];

endmodule

// ==== design/pipe_stage_reg.sv ====
module pipe_stage_reg
    import rv32_pipe_pkg::*;
#(
    parameter int               WIDTH     = 32,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_i,
    input  logic             valid_i,
    input  logic [WIDTH-1:0] data_i,
    output logic             valid_o,
    output logic [WIDTH-1:0] data_o
);

    logic             valid_q;
    logic [WIDTH-1:0] data_q;

    // valid follows upstream on every loading edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= valid_i;
        end
    end

    // a bubble leaves the payload as it was
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_q <= RESET_VAL;
        end else if (load_i && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== design/rv32_pipe_pkg.sv ====
`include "pipe_defs.svh"

package rv32_pipe_pkg;

    // address, data and pc
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`MASK_W-1:0] byte_en_t;

    // raw funct3 field as decoded
    typedef logic [2:0] funct3_t;

    // RV32I load widths
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // RV32I store widths
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // memory address source
    typedef enum logic {
        pc_sel  = 1'b0,
        alu_sel = 1'b1
    } mar_sel_e;

endpackage

// ==== include/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// data and address width
`define XLEN 32

// one enable bit per byte of a word
`define MASK_W 4

// boot address, reset value of every pc register
`define RESET_PC 32'h4000_0000

`endif

// ==== project.f ====
+incdir+include
design/rv32_pipe_pkg.sv
design/pipe_stage_reg.sv
design/mem_req_gen.sv
design/exe_mem_reg.sv
design/pipe_regs_top.sv
tests/tb_clk_gen.sv
tests/pipe_regs_sva.sv
tests/pipe_regs_tb.sv

// ==== tests/pipe_regs_sva.sv ====
`include "pipe_defs.svh"

module pipe_regs_sva
    import rv32_pipe_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     load_i,
    input logic     in_valid_i,
    input word_t    in_pc_i,
    input word_t    in_alu_i,
    input word_t    in_rs2_i,
    input logic     in_mem_read_i,
    input logic     in_mem_write_i,
    input funct3_t  in_funct3_i,
    input mar_sel_e in_mar_sel_i,
    input word_t    mem_rdata_i,
    input word_t    mem_addr_o,
    input word_t    mem_wdata_o,
    input byte_en_t mem_byte_en_o,
    input logic     mem_read_o,
    input logic     mem_write_o,
    input logic     mem_trap_o,
    input logic     mem_valid_o,
    input logic     wb_valid_o,
    input word_t    wb_pc_o,
    input word_t    wb_alu_o,
    input word_t    wb_rdata_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic f_rst = 1'b0;
    logic f_req = 1'b0;
    logic f_flags = 1'b0;
    logic f_trap = 1'b0;
    logic f_excl = 1'b0;
    logic f_wb = 1'b0;
    logic f_stall = 1'b0;
    logic any_fail;

    // saturating count of edges since reset release
    logic [3:0] cnt;
    logic ld1, ld2, ld3, v1, v2, v3, rd1, rd2, wr1, wr2, sel1, sel2;
    word_t pc1, pc2, pc3, alu1, alu2, alu3, rs21, rs22, rdat1;
    funct3_t f31, f32;
    logic [168:0] outs, outs1;

    word_t    exp_addr;
    byte_en_t exp_mask;
    logic     exp_legal;
    word_t    raw;

    assign any_fail = f_rst | f_req | f_flags | f_trap | f_excl | f_wb | f_stall;
    assign outs = {mem_addr_o, mem_wdata_o, mem_byte_en_o, mem_read_o, mem_write_o,
                   mem_trap_o, mem_valid_o, wb_valid_o, wb_pc_o, wb_alu_o, wb_rdata_o};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt != 4'hf) begin
            cnt <= cnt + 4'd1;
        end
    end

    // input history up to three edges back
    always_ff @(posedge clk) begin
        ld1 <= load_i;
        ld2 <= ld1;
        ld3 <= ld2;
        v1 <= in_valid_i;
        v2 <= v1;
        v3 <= v2;
        pc1 <= in_pc_i;
        pc2 <= pc1;
        pc3 <= pc2;
        alu1 <= in_alu_i;
        alu2 <= alu1;
        alu3 <= alu2;
        rs21 <= in_rs2_i;
        rs22 <= rs21;
        rdat1 <= mem_rdata_i;
        rd1 <= in_mem_read_i;
        rd2 <= rd1;
        wr1 <= in_mem_write_i;
        wr2 <= wr1;
        f31 <= in_funct3_i;
        f32 <= f31;
        sel1 <= in_mar_sel_i;
        sel2 <= sel1;
        outs1 <= outs;
    end

    // expected request for the packet two edges back
    always_comb begin
        raw = sel2 ? alu2 : pc2;
        if (rd2) begin
            exp_legal = (f32 != 3'b011) && (f32 != 3'b110) && (f32 != 3'b111);
        end else begin
            exp_legal = (f32 == 3'b000) || (f32 == 3'b001) || (f32 == 3'b010);
        end
        exp_addr = raw;
        exp_mask = 4'b1111;
        if (f32[1:0] == 2'b00) begin
            exp_addr = raw & 32'hffff_fffc;
            case (raw[1:0])
                2'd0: exp_mask = 4'b0001;
                2'd1: exp_mask = 4'b0010;
                2'd2: exp_mask = 4'b0100;
                default: exp_mask = 4'b1000;
            endcase
        end else if (f32[1:0] == 2'b01) begin
            exp_addr = raw & 32'hffff_fffc;
            case (raw[1:0])
                2'd0: exp_mask = 4'b0011;
                2'd1: exp_mask = 4'b0110;
                2'd2: exp_mask = 4'b1100;
                default: exp_mask = 4'b1000;
            endcase
        end
    end

    reset_state: assert property (@(posedge clk) (rst || $fell(rst)) |->
        (!mem_valid_o && !wb_valid_o && !mem_read_o && !mem_write_o && !mem_trap_o
         && mem_byte_en_o == '0 && wb_pc_o == `RESET_PC))
        else begin
            $error("FAIL reset_state expected pc %h actual %h", `RESET_PC, wb_pc_o);
            f_rst = 1'b1;
        end

    req_form: assert property (@(posedge clk) disable iff (rst)
        (cnt >= 2 && ld1 && ld2 && v2 && (rd2 || wr2) && exp_legal) |->
        (mem_addr_o == exp_addr && mem_byte_en_o == exp_mask
         && (rd2 || mem_wdata_o == rs22)))
        else begin
            $error("FAIL req_form expected %h/%b/%h actual %h/%b/%h",
                   exp_addr, exp_mask, rs22, mem_addr_o, mem_byte_en_o, mem_wdata_o);
            f_req = 1'b1;
        end

    req_flags: assert property (@(posedge clk) disable iff (rst)
        (cnt >= 2 && ld1 && ld2) |->
        (mem_valid_o == v2 && mem_read_o == (v2 && rd2)
         && mem_write_o == (v2 && wr2 && !rd2)))
        else begin
            $error("FAIL req_flags expected %b/%b/%b actual %b/%b/%b",
                   v2, v2 && rd2, v2 && wr2 && !rd2, mem_valid_o, mem_read_o, mem_write_o);
            f_flags = 1'b1;
        end

    trap_rule: assert property (@(posedge clk) disable iff (rst)
        (cnt >= 2 && ld1 && ld2 && v2) |-> (mem_trap_o == ((rd2 || wr2) && !exp_legal)))
        else begin
            $error("FAIL trap_rule expected %b actual %b",
                   (rd2 || wr2) && !exp_legal, mem_trap_o);
            f_trap = 1'b1;
        end

    req_excl: assert property (@(posedge clk)
        !(mem_read_o && mem_write_o) && (mem_valid_o || (!mem_read_o && !mem_write_o)))
        else begin
            $error("request flags both high or active without a valid stage");
            f_excl = 1'b1;
        end

    wb_latency: assert property (@(posedge clk) disable iff (rst)
        (cnt >= 3 && ld1 && ld2 && ld3) |->
        (wb_valid_o == v3
         && (!v3 || (wb_pc_o == pc3 && wb_alu_o == alu3 && wb_rdata_o == rdat1))))
        else begin
            $error("FAIL wb_latency expected %b/%h/%h/%h actual %b/%h/%h/%h",
                   v3, pc3, alu3, rdat1, wb_valid_o, wb_pc_o, wb_alu_o, wb_rdata_o);
            f_wb = 1'b1;
        end

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (cnt >= 2 && !ld1) |-> (outs == outs1))
        else begin
            $error("FAIL stall_hold expected %h actual %h", outs1, outs);
            f_stall = 1'b1;
        end

endmodule

// ==== tests/pipe_regs_tb.sv ====
module pipe_regs_tb
    import rv32_pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PKT = 200;
    // two phases of 200 loads, stalls in phase 2 and margin
    localparam int MAX_CYCLES = 1000;

    logic clk, rst, load, in_valid, in_rd, in_wr, mem_read, mem_write, mem_trap;
    logic mem_valid, wb_valid;
    word_t in_pc, in_alu, in_rs2, rdata, mem_addr, mem_wdata, wb_pc, wb_alu, wb_rdata;
    funct3_t in_funct3;
    mar_sel_e in_sel;
    byte_en_t mem_byte_en;
    logic [31:0] lcg_state = 32'd4368;
    int cycles = 0;

    bind pipe_regs_top pipe_regs_sva u_sva (.*);

    tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

    pipe_regs_top i_dut (
        .clk(clk), .rst(rst), .load_i(load), .in_valid_i(in_valid),
        .in_pc_i(in_pc), .in_alu_i(in_alu), .in_rs2_i(in_rs2),
        .in_mem_read_i(in_rd), .in_mem_write_i(in_wr), .in_funct3_i(in_funct3),
        .in_mar_sel_i(in_sel), .mem_rdata_i(rdata),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_byte_en_o(mem_byte_en),
        .mem_read_o(mem_read), .mem_write_o(mem_write), .mem_trap_o(mem_trap),
        .mem_valid_o(mem_valid), .wb_valid_o(wb_valid), .wb_pc_o(wb_pc),
        .wb_alu_o(wb_alu), .wb_rdata_o(wb_rdata)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // new random packet; op 3 sends read and write together
    task automatic drive_packet();
        logic [31:0] r;
        r = lcg_next();
        in_valid  <= r[20];
        in_rd     <= (r[23:22] == 2'd1) || (r[23:22] == 2'd3);
        in_wr     <= r[23];
        in_funct3 <= r[26:24];
        in_sel    <= mar_sel_e'(r[27]);
        in_pc     <= lcg_next();
        in_alu    <= lcg_next();
        in_rs2    <= lcg_next();
        rdata     <= lcg_next();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within the cycle limit");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (i_dut.u_sva.any_fail) begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    initial begin
        int loads;
        logic [31:0] r;
        load = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_alu = '0;
        in_rs2 = '0;
        in_rd = 1'b0;
        in_wr = 1'b0;
        in_funct3 = '0;
        in_sel = pc_sel;
        rdata = '0;
        wait (rst == 1'b0);
        for (int i = 0; i < NUM_PKT; i++) begin
            @(posedge clk);
            load <= 1'b1;
            drive_packet();
        end
        // phase 2 with back-pressure about one cycle in three
        loads = 0;
        while (loads < NUM_PKT) begin
            @(posedge clk);
            r = lcg_next();
            if ((r[31:16] % 3) == 0) begin
                load <= 1'b0;
            end else begin
                load <= 1'b1;
                loads++;
            end
            drive_packet();
        end
        @(posedge clk);
        load <= 1'b1;
        in_valid <= 1'b0;
        repeat (5) @(posedge clk);
        // checks of the last edge have run by the falling edge
        @(negedge clk);
        if (i_dut.u_sva.any_fail) begin
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset raised before the first edge, held over the first two rising edges
    initial begin
        rst_o = 1'b0;
        #1 rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule
